/* files.f */
+incdir+test
hdl/mon_char_pkg.sv
hdl/mon_cmd_pkg.sv
hdl/char_decoder.sv
hdl/hex_word_assembler.sv
hdl/cmd_fsm.sv
hdl/breakpoint_reg.sv
hdl/uart_monitor.sv
test/uart_monitor_assert.sv
test/tb_uart_monitor.sv

/* hdl/breakpoint_reg.sv */
// single breakpoint on a word address, pc bits 1:0 ignored
// hit is only reported while the cpu runs
`timescale 1ns/10ps

module breakpoint_reg
	import mon_cmd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              bp_load,      // s word completed
	input  mon_word_u         word,
	input  logic [WORD_W-1:0] pc_data,
	input  logic              cpu_run_state,
	output logic              bp_hit
);

	logic [WORD_W-3:0] bp_addr_q; // stored word address
	logic              bp_en_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bp_addr_q <= '0;
			bp_en_q   <= 1'b0; // disabled out of reset
		end else if (bp_load) begin
			bp_addr_q <= word.bp.bp_addr;
			bp_en_q   <= ~word.bp.bp_disable; // bit 0 set turns it off
		end
	end

	// compare on pc bits 31:2
	assign bp_hit = bp_en_q & cpu_run_state & (pc_data[WORD_W-1:2] == bp_addr_q);

endmodule

/* hdl/char_decoder.sv */
// sorts each received character into a hex nibble or a command strobe
// rx_valid is a one cycle strobe, at most one character per cycle
// all outputs are one cycle after rx_valid and last one cycle
`timescale 1ns/10ps

module char_decoder
	import mon_char_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [CHAR_W-1:0] rx_char,
	input  logic              rx_valid,
	output logic [3:0]        nibble,    // digit value, qualified by hex_valid
	output logic              hex_valid,
	output logic              cmd_g,
	output logic              cmd_quit,
	output logic              cmd_w,
	output logic              cmd_r,
	output logic              cmd_t,
	output logic              cmd_s,
	output logic              cmd_cr
);

	logic [CHAR_W-1:0]   char_q;  // held character
	logic                valid_q; // delayed rx_valid
	logic [CLS_BITS-1:0] cls;     // class of held character
	logic [3:0]          nib;

	always_ff @(posedge clk) begin
		if (rx_valid)
			char_q <= rx_char; // capture only on strobe
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= rx_valid;
	end

	// classify held character
	always_comb begin
		cls = CLS_NONE;
		nib = 4'h0;
		if (char_q >= CHR_0 && char_q <= CHR_9) begin
			cls = CLS_HEX;
			nib = char_q[3:0]; // '0'..'9' low nibble is the value
		end else if (char_q >= CHR_LC_A && char_q <= CHR_LC_F) begin
			cls = CLS_HEX;
			nib = char_q[3:0] + 4'd9; // 'a' is 0x61 -> 10
		end else begin
			case (char_q)
				CHR_G:      cls = CLS_GO;
				CHR_CTRL_C: cls = CLS_QUIT;
				CHR_W:      cls = CLS_WRITE;
				CHR_R:      cls = CLS_READ;
				CHR_T:      cls = CLS_TRASH;
				CHR_S:      cls = CLS_SET;
				CHR_CR:     cls = CLS_CR;
				default:    cls = CLS_NONE; // upper case, punctuation etc
			endcase
		end
	end

	assign nibble = nib;

	// qualify with delayed valid
	assign hex_valid = valid_q & (cls == CLS_HEX);
	assign cmd_g     = valid_q & (cls == CLS_GO);
	assign cmd_quit  = valid_q & (cls == CLS_QUIT);
	assign cmd_w     = valid_q & (cls == CLS_WRITE);
	assign cmd_r     = valid_q & (cls == CLS_READ);
	assign cmd_t     = valid_q & (cls == CLS_TRASH);
	assign cmd_s     = valid_q & (cls == CLS_SET);
	assign cmd_cr    = valid_q & (cls == CLS_CR);

endmodule

/* hdl/cmd_fsm.sv */
// command state machine of the monitor
// strobes are combinational from the decoder and word_valid cycles
// cpu_start is delayed three cycles from the g address word
// dump_running and trash_running only hold R_DUMP and TRASH
`timescale 1ns/10ps

module cmd_fsm
	import mon_cmd_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_g,
	input  logic cmd_quit,
	input  logic cmd_w,
	input  logic cmd_r,
	input  logic cmd_t,
	input  logic cmd_s,
	input  logic cmd_cr,
	input  logic word_valid,
	input  logic dump_running,
	input  logic trash_running,
	input  logic cpu_run_state,
	input  logic bp_hit,
	output logic digit_window,
	output logic word_start,
	output logic bp_load,
	output logic write_address_set,
	output logic write_data_en,
	output logic read_start_set,
	output logic read_end_set,
	output logic read_stop,
	output logic start_trash,
	output logic quit_cmd,
	output logic crlf_in,
	output logic cpu_start
);

	cmd_state_t state;
	cmd_state_t state_nxt;
	logic       g_step; // address taken, cpu about to run
	logic       w_step;
	logic       r_step;
	logic       s_step;
	logic [2:0] start_dly;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				// g over w over r over t over s
				if (cmd_g)
					state_nxt = G_ADDR;
				else if (cmd_w)
					state_nxt = W_ADDR;
				else if (cmd_r)
					state_nxt = R_START;
				else if (cmd_t)
					state_nxt = TRASH;
				else if (cmd_s)
					state_nxt = S_ADDR;
			end
			G_ADDR:  if (cmd_quit) state_nxt = IDLE; else if (word_valid) state_nxt = G_RUN;
			G_RUN:   if (cmd_quit || bp_hit) state_nxt = IDLE;
			W_ADDR:  if (cmd_quit) state_nxt = IDLE; else if (word_valid) state_nxt = W_DATA;
			W_DATA:  if (cmd_quit) state_nxt = IDLE; // data words until quit
			R_START: if (cmd_quit) state_nxt = IDLE; else if (word_valid) state_nxt = R_END;
			R_END:   if (cmd_quit) state_nxt = IDLE; else if (word_valid) state_nxt = R_DUMP;
			R_DUMP:  if (cmd_quit || !dump_running) state_nxt = IDLE;
			TRASH:   if (cmd_quit || !trash_running) state_nxt = IDLE;
			S_ADDR:  if (cmd_quit || word_valid) state_nxt = IDLE; // one word only
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// states that collect hex words
	assign digit_window = (state == G_ADDR) | (state == W_ADDR) | (state == W_DATA)
		| (state == R_START) | (state == R_END) | (state == S_ADDR);

	// restart digit count on a numeric command
	assign word_start = (state == IDLE) & ((state_nxt == G_ADDR) | (state_nxt == W_ADDR)
		| (state_nxt == R_START) | (state_nxt == S_ADDR));

	// word strobes, same cycle as word_valid
	assign write_address_set = (state == W_ADDR) & word_valid;
	assign write_data_en     = (state == W_DATA) & word_valid;
	assign read_start_set    = (state == R_START) & word_valid;
	assign read_end_set      = (state == R_END) & word_valid;
	assign bp_load           = (state == S_ADDR) & word_valid;

	assign read_stop   = (state == R_DUMP) & cmd_quit; // abort dump
	assign start_trash = (state == IDLE) & cmd_t;
	assign quit_cmd    = cmd_quit | bp_hit;            // breakpoint acts as quit

	// line feed terms
	assign g_step = (state == G_ADDR) & (state_nxt == G_RUN);
	assign w_step = (state == W_ADDR) & (state_nxt == W_DATA);
	assign r_step = (state == R_END) & (state_nxt == R_DUMP);
	assign s_step = (state == S_ADDR) & word_valid;

	assign crlf_in = cmd_quit | cmd_cr | (cmd_t & ~cpu_run_state)
		| g_step | w_step | r_step | s_step;

	// cpu start, three stages after g_step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			start_dly <= 3'b000;
		else
			start_dly <= {start_dly[1:0], g_step};
	end

	assign cpu_start = start_dly[2];

endmodule

/* hdl/hex_word_assembler.sv */
// packs hex nibbles into a word, eight digits per word
// digits are taken only while digit_window is high
// word and word_valid come one cycle after the eighth digit strobe
`timescale 1ns/10ps

module hex_word_assembler
	import mon_cmd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] nibble,
	input  logic       hex_valid,
	input  logic       digit_window, // state accepts numbers
	input  logic       word_start,   // numeric command accepted in IDLE
	input  logic       quit,
	output mon_word_u  word,
	output logic       word_valid    // one cycle, with the new word
);

	logic [WORD_W-1:0]      shift_q;
	logic [WORD_W-1:0]      shifted;
	logic [DIGIT_CNT_W-1:0] cnt_q;   // digits taken in current word
	logic                   take;
	logic                   last_digit;

	assign take       = hex_valid & digit_window;
	assign shifted    = {shift_q[WORD_W-5:0], nibble}; // new digit at low end
	assign last_digit = take & (cnt_q == DIGIT_CNT_W'(DIGITS_PER_WORD - 1));

	// shift register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			shift_q <= '0;
		else if (quit)
			shift_q <= '0; // drop partial word
		else if (take)
			shift_q <= shifted;
	end

	// digit counter, wraps to 0 after the last digit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt_q <= '0;
		else if (word_start || quit)
			cnt_q <= '0;
		else if (take)
			cnt_q <= cnt_q + 1'b1;
	end

	// output word, loaded with the completing digit included
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			word <= '0;
		else if (last_digit)
			word.data <= shifted;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			word_valid <= 1'b0;
		else
			word_valid <= last_digit; // aligned with the loaded word
	end

endmodule

/* hdl/mon_char_pkg.sv */
// received character codes for the monitor command line
// hex digits are '0'..'9' and lower case 'a'..'f' only, upper case is not a digit
// class codes are internal to the decoder, one class per character
package mon_char_pkg;

	localparam int CHAR_W = 8; // one uart character

	// command letters
	localparam logic [CHAR_W-1:0] CHR_CTRL_C = 8'h03; // quit from any command
	localparam logic [CHAR_W-1:0] CHR_CR     = 8'h0d; // line feed request
	localparam logic [CHAR_W-1:0] CHR_G      = 8'h67; // go to address and run
	localparam logic [CHAR_W-1:0] CHR_W      = 8'h77; // write data memory
	localparam logic [CHAR_W-1:0] CHR_R      = 8'h72; // read and dump data memory
	localparam logic [CHAR_W-1:0] CHR_T      = 8'h74; // trash memory to zero
	localparam logic [CHAR_W-1:0] CHR_S      = 8'h73; // set breakpoint

	// hex digit ranges
	localparam logic [CHAR_W-1:0] CHR_0    = 8'h30;
	localparam logic [CHAR_W-1:0] CHR_9    = 8'h39;
	localparam logic [CHAR_W-1:0] CHR_LC_A = 8'h61;
	localparam logic [CHAR_W-1:0] CHR_LC_F = 8'h66;

	// decoded classes
	localparam int CLS_BITS = 4;
	localparam logic [CLS_BITS-1:0] CLS_NONE  = 4'd0; // unknown, ignored
	localparam logic [CLS_BITS-1:0] CLS_HEX   = 4'd1; // digit, nibble valid
	localparam logic [CLS_BITS-1:0] CLS_GO    = 4'd2;
	localparam logic [CLS_BITS-1:0] CLS_QUIT  = 4'd3;
	localparam logic [CLS_BITS-1:0] CLS_WRITE = 4'd4;
	localparam logic [CLS_BITS-1:0] CLS_READ  = 4'd5;
	localparam logic [CLS_BITS-1:0] CLS_TRASH = 4'd6;
	localparam logic [CLS_BITS-1:0] CLS_SET   = 4'd7;
	localparam logic [CLS_BITS-1:0] CLS_CR    = 4'd8;

endpackage

/* hdl/mon_cmd_pkg.sv */
// command level definitions, state encoding and the assembled word
// a word is always eight hex digits, most significant digit typed first
// the breakpoint view ignores bit 1 of the word
package mon_cmd_pkg;

	localparam int WORD_W          = 32; // data and address width
	localparam int DIGITS_PER_WORD = 8;  // hex digits per word
	localparam int DIGIT_CNT_W     = $clog2(DIGITS_PER_WORD); // wraps after last digit

	// command states, 4 bit encoding
	typedef enum logic [3:0] {
		IDLE    = 4'd0, // waiting for a command letter
		G_ADDR  = 4'd1, // g, collecting start address
		G_RUN   = 4'd2, // cpu running until quit or breakpoint
		W_ADDR  = 4'd3, // w, collecting write address
		W_DATA  = 4'd4, // w, data words until quit
		R_START = 4'd5, // r, start address
		R_END   = 4'd6, // r, end address
		R_DUMP  = 4'd7, // dump in progress
		TRASH   = 4'd8, // memory clear in progress
		S_ADDR  = 4'd9  // s, breakpoint word
	} cmd_state_t;

	// breakpoint reading of the word
	typedef struct packed {
		logic [WORD_W-3:0] bp_addr;    // word address, pc bits 31:2
		logic              rsvd;       // not used
		logic              bp_disable; // 1 clears the enable
	} bp_word_t;

	// one assembled word, two readings
	typedef union packed {
		logic [WORD_W-1:0] data; // plain data or address
		bp_word_t          bp;   // breakpoint setting
	} mon_word_u;

endpackage

/* hdl/uart_monitor.sv */
// command front end of the uart debug monitor
// memory, dump, trash and run logic sit outside and use the strobes
// no back-pressure, characters are taken as they arrive
`timescale 1ns/10ps

module uart_monitor
	import mon_char_pkg::*;
	import mon_cmd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [CHAR_W-1:0] rx_char,
	input  logic              rx_valid,
	input  logic              dump_running,
	input  logic              trash_running,
	input  logic              cpu_run_state,
	input  logic [WORD_W-1:0] pc_data,
	output logic [WORD_W-1:0] uart_data, // last assembled word
	output logic              cpu_start,
	output logic              write_address_set,
	output logic              write_data_en,
	output logic              read_start_set,
	output logic              read_end_set,
	output logic              read_stop,
	output logic              start_trash,
	output logic              quit_cmd,
	output logic              crlf_in
);

	logic [3:0] nibble;
	logic       hex_valid;
	logic       cmd_g, cmd_quit, cmd_w, cmd_r, cmd_t, cmd_s, cmd_cr;
	logic       digit_window, word_start, word_valid;
	logic       bp_load, bp_hit;
	mon_word_u  word;

	char_decoder i_dec (
		.clk(clk), .rst_n(rst_n), .rx_char(rx_char), .rx_valid(rx_valid),
		.nibble(nibble), .hex_valid(hex_valid),
		.cmd_g(cmd_g), .cmd_quit(cmd_quit), .cmd_w(cmd_w), .cmd_r(cmd_r),
		.cmd_t(cmd_t), .cmd_s(cmd_s), .cmd_cr(cmd_cr)
	);

	// quit straight from the decoder drops a partial word
	hex_word_assembler i_asm (
		.clk(clk), .rst_n(rst_n), .nibble(nibble), .hex_valid(hex_valid),
		.digit_window(digit_window), .word_start(word_start), .quit(cmd_quit),
		.word(word), .word_valid(word_valid)
	);

	cmd_fsm i_fsm (
		.clk(clk), .rst_n(rst_n),
		.cmd_g(cmd_g), .cmd_quit(cmd_quit), .cmd_w(cmd_w), .cmd_r(cmd_r),
		.cmd_t(cmd_t), .cmd_s(cmd_s), .cmd_cr(cmd_cr),
		.word_valid(word_valid), .dump_running(dump_running),
		.trash_running(trash_running), .cpu_run_state(cpu_run_state), .bp_hit(bp_hit),
		.digit_window(digit_window), .word_start(word_start), .bp_load(bp_load),
		.write_address_set(write_address_set), .write_data_en(write_data_en),
		.read_start_set(read_start_set), .read_end_set(read_end_set),
		.read_stop(read_stop), .start_trash(start_trash), .quit_cmd(quit_cmd),
		.crlf_in(crlf_in), .cpu_start(cpu_start)
	);

	breakpoint_reg i_bp (
		.clk(clk), .rst_n(rst_n), .bp_load(bp_load), .word(word),
		.pc_data(pc_data), .cpu_run_state(cpu_run_state), .bp_hit(bp_hit)
	);

	assign uart_data = word.data; // plain data view

endmodule

/* run.sh */
#!/bin/bash
# build and run with Verilator, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_uart_monitor -o sim &&
./obj_dir/sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

/* test/mon_model.svh */
// reference model of the monitor word assembly and the expected strobes
// words are typed as eight lower case hex digits with the most significant first
`ifndef MON_MODEL_SVH
`define MON_MODEL_SVH

localparam int MODEL_WORD_DLY  = 2; // rx_valid of last digit to word strobe
localparam int MODEL_START_DLY = 3; // word strobe of g address to cpu_start

// ascii character for one digit
function automatic logic [7:0] hex_char(input logic [3:0] nib);
	logic [7:0] c;
	if (nib < 4'd10)
		c = 8'h30 + {4'h0, nib}; // '0'..'9'
	else
		c = 8'h61 + {4'h0, nib} - 8'd10; // 'a'..'f'
	return c;
endfunction

// one typed digit enters at the low end
function automatic logic [31:0] push_digit(input logic [31:0] acc, input logic [3:0] nib);
	logic [31:0] nxt;
	nxt = {acc[27:0], nib};
	return nxt;
endfunction

// line feed expected for t only while the cpu is stopped
function automatic int trash_crlf_count(input logic cpu_running);
	int n;
	n = cpu_running ? 0 : 1;
	return n;
endfunction

// breakpoint fires on word address match when enabled
function automatic logic bp_hit_expected(input logic [31:0] bp_word, input logic [31:0] pc,
	input logic running);
	logic hit;
	hit = running & ~bp_word[0] & (pc[31:2] == bp_word[31:2]);
	return hit;
endfunction

`endif

/* test/tb_uart_monitor.sv */
// uart monitor front end testbench with random digits and gaps from a fixed seed
// inputs change 10 ns after the rising edge and outputs are sampled on the falling edge
`timescale 1ns/10ps

module tb_uart_monitor
	import mon_char_pkg::*;
	import mon_cmd_pkg::*;
();

	`include "mon_model.svh"

	localparam int S_WAS = 0, S_WDE = 1, S_RSS = 2, S_RES = 3, S_RSTOP = 4;
	localparam int S_TRASH = 5, S_QUIT = 6, S_CRLF = 7, S_START = 8, N_STROBES = 9;

	logic clk, rst_n, rx_valid, dump_running, trash_running, cpu_run_state;
	logic [CHAR_W-1:0] rx_char;
	logic [WORD_W-1:0] pc_data, uart_data;
	logic cpu_start, write_address_set, write_data_en, read_start_set, read_end_set;
	logic read_stop, start_trash, quit_cmd, crlf_in;

	integer seed = 32'hef6fd299;
	int cyc = 0;
	int last_rx_cyc, wde_cyc, start_cyc;
	int cnt [N_STROBES];
	logic [WORD_W-1:0] was_data, wde_data, rss_data, res_data, quit_pc;
	int n_checks = 0, n_errors = 0;

	uart_monitor i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// strobe counters and captured data
	always @(negedge clk) begin
		if (rst_n) begin
			if (write_address_set) begin
				cnt[S_WAS]++;
				was_data = uart_data;
			end
			if (write_data_en) begin
				cnt[S_WDE]++;
				wde_data = uart_data;
				wde_cyc = cyc; // cycle of the word strobe
			end
			if (read_start_set) begin
				cnt[S_RSS]++;
				rss_data = uart_data;
			end
			if (read_end_set) begin
				cnt[S_RES]++;
				res_data = uart_data;
			end
			if (read_stop)
				cnt[S_RSTOP]++;
			if (start_trash)
				cnt[S_TRASH]++;
			if (quit_cmd) begin
				cnt[S_QUIT]++;
				quit_pc = pc_data;
			end
			if (crlf_in)
				cnt[S_CRLF]++;
			if (cpu_start) begin
				cnt[S_START]++;
				start_cyc = cyc;
			end
		end
	end

	// hard limit on run time
	initial begin
		repeat (20000) @(posedge clk);
		$display("simulation timed out before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		assert (exp === act) else begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic require(input logic cond, input string msg);
		n_checks++;
		assert (cond) else begin
			n_errors++;
			$display("%s", msg);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	// one character strobe with the next one 1 to 4 cycles later
	task automatic send_char(input logic [7:0] c);
		int gap;
		rx_char = c;
		rx_valid = 1'b1;
		last_rx_cyc = cyc;
		idle(1);
		rx_valid = 1'b0;
		gap = $random(seed) & 3;
		idle(gap);
	endtask

	task automatic send_word(input logic [31:0] value, output logic [31:0] exp);
		logic [3:0] nib;
		exp = '0;
		for (int i = DIGITS_PER_WORD - 1; i >= 0; i--) begin
			nib = value[i*4 +: 4];
			send_char(hex_char(nib));
			exp = push_digit(exp, nib);
		end
	endtask

	task automatic wait_count(input int id, input int target, input string what);
		int t;
		t = 0;
		while (cnt[id] < target && t < 200) begin
			idle(1);
			t++;
		end
		require(cnt[id] >= target, {"timed out waiting for ", what});
	endtask

	task automatic write_words();
		logic [31:0] exp;
		int n, was0, wde0, q0, c0;
		n = 1 + ($random(seed) & 3); // data words
		was0 = cnt[S_WAS];
		wde0 = cnt[S_WDE];
		send_char(CHR_W);
		send_word($random(seed), exp);
		wait_count(S_WAS, was0 + 1, "write address strobe");
		compare("write address", exp, was_data);
		for (int i = 0; i < n; i++) begin
			c0 = cnt[S_WDE];
			send_word($random(seed), exp);
			wait_count(S_WDE, c0 + 1, "write data strobe");
			compare("write data", exp, wde_data);
			compare("write data delay", MODEL_WORD_DLY, wde_cyc - last_rx_cyc);
		end
		q0 = cnt[S_QUIT];
		c0 = cnt[S_CRLF];
		send_char(CHR_CTRL_C);
		wait_count(S_QUIT, q0 + 1, "quit on ctrl-c");
		wait_count(S_CRLF, c0 + 1, "line feed on ctrl-c");
		compare("write address count", was0 + 1, cnt[S_WAS]);
		compare("write data count", wde0 + n, cnt[S_WDE]);
	endtask

	task automatic read_range(input logic abort);
		logic [31:0] exp;
		int r0, e0, s0, w0;
		r0 = cnt[S_RSS];
		e0 = cnt[S_RES];
		dump_running = 1'b1;
		send_char(CHR_R);
		send_word($random(seed), exp);
		wait_count(S_RSS, r0 + 1, "read start strobe");
		compare("read start", exp, rss_data);
		send_word($random(seed), exp);
		wait_count(S_RES, e0 + 1, "read end strobe");
		compare("read end", exp, res_data);
		idle(1 + ($random(seed) & 7)); // dump length
		if (abort) begin
			s0 = cnt[S_RSTOP];
			send_char(CHR_CTRL_C);
			wait_count(S_RSTOP, s0 + 1, "read stop on ctrl-c");
			dump_running = 1'b0;
		end else begin
			dump_running = 1'b0;
			idle(2);
			w0 = cnt[S_WAS];
			send_char(CHR_W);
			send_word($random(seed), exp);
			wait_count(S_WAS, w0 + 1, "write address after dump");
			compare("write address after dump", exp, was_data);
			send_char(CHR_CTRL_C);
		end
		idle(2);
	endtask

	task automatic go_and_start();
		logic [31:0] exp;
		int s0, c0;
		s0 = cnt[S_START];
		c0 = cnt[S_CRLF];
		send_char(CHR_G);
		send_word($random(seed), exp);
		wait_count(S_START, s0 + 1, "cpu start");
		compare("go line feed", c0 + 1, cnt[S_CRLF]);
		compare("cpu start delay", MODEL_WORD_DLY + MODEL_START_DLY,
			start_cyc - last_rx_cyc);
		send_char(CHR_CTRL_C);
		idle(2);
	endtask

	task automatic breakpoint_run(input logic disable_bit);
		logic [31:0] bpw, exp, base;
		int q0, s0, hit_exp;
		bpw = $random(seed);
		bpw[0] = disable_bit;
		send_char(CHR_S);
		send_word(bpw, exp);
		idle(2); // breakpoint loaded, back in IDLE
		s0 = cnt[S_START];
		send_char(CHR_G);
		send_word($random(seed), exp);
		wait_count(S_START, s0 + 1, "cpu start before breakpoint run");
		base = {bpw[31:2] - 30'd8, 2'b00}; // pc walks across the breakpoint
		bpw = {bpw[31:2], 1'b0, disable_bit};
		pc_data = base;
		cpu_run_state = 1'b1;
		q0 = cnt[S_QUIT];
		hit_exp = 0;
		for (int i = 0; i < 16; i++) begin
			pc_data = base + 32'(i * 4);
			if (bp_hit_expected(bpw, pc_data, 1'b1))
				hit_exp++;
			idle(1);
		end
		compare("breakpoint quits", hit_exp, cnt[S_QUIT] - q0);
		if (hit_exp != 0)
			compare("breakpoint pc", {bpw[31:2], 2'b00}, {quit_pc[31:2], 2'b00});
		cpu_run_state = 1'b0;
		pc_data = '0;
		send_char(CHR_CTRL_C);
		idle(2);
	endtask

	task automatic trash_and_junk();
		int t0, c0, total;
		logic [7:0] junk [6];
		for (int run = 0; run < 2; run++) begin
			cpu_run_state = (run == 1);
			t0 = cnt[S_TRASH];
			c0 = cnt[S_CRLF];
			send_char(CHR_T);
			wait_count(S_TRASH, t0 + 1, "start trash");
			idle(2);
			compare("trash line feed", c0 + trash_crlf_count(cpu_run_state), cnt[S_CRLF]);
		end
		cpu_run_state = 1'b0;
		c0 = cnt[S_CRLF];
		send_char(CHR_CR);
		wait_count(S_CRLF, c0 + 1, "line feed on cr");
		junk = '{8'h41, 8'h46, 8'h78, 8'h23, 8'h35, 8'h63}; // A F x # 5 c
		total = 0;
		foreach (cnt[i]) total += cnt[i];
		foreach (junk[i]) send_char(junk[i]);
		idle(4);
		foreach (cnt[i]) total -= cnt[i];
		compare("ignored characters", 0, total);
	endtask

	initial begin
		rst_n = 1'b0;
		rx_valid = 1'b0;
		rx_char = '0;
		dump_running = 1'b0;
		trash_running = 1'b0;
		cpu_run_state = 1'b0;
		pc_data = '0;
		foreach (cnt[i]) cnt[i] = 0;
		repeat (10) @(posedge clk);
		#10;
		rst_n = 1'b1;
		idle(2);
		write_words();
		write_words();
		read_range(1'b0);
		read_range(1'b1);
		go_and_start();
		breakpoint_run(1'b0);
		breakpoint_run(1'b1);
		trash_and_junk();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* test/uart_monitor_assert.sv */
// bound into cmd_fsm, checks state encoding and strobe rules
// only active outside reset
`timescale 1ns/10ps

module uart_monitor_assert
	import mon_cmd_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input cmd_state_t state,
	input logic       cmd_quit,
	input logic       g_step,
	input logic       write_address_set,
	input logic       write_data_en,
	input logic       read_start_set,
	input logic       read_end_set,
	input logic       bp_load,
	input logic       cpu_start
);

	a_legal_state: assert property (@(posedge clk) disable iff (!rst_n) state <= S_ADDR)
		else $error("state register holds an illegal encoding");

	a_quit_idle: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_quit |=> state == IDLE)
		else $error("quit did not return the state machine to IDLE");

	// one word feeds one strobe only
	a_set_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({write_address_set, write_data_en, read_start_set, read_end_set, bp_load}))
		else $error("two set strobes high in the same cycle");

	a_cpu_start: assert property (@(posedge clk) disable iff (!rst_n)
		g_step |-> ##3 cpu_start)
		else $error("cpu_start missing three cycles after the g address");

endmodule

bind cmd_fsm uart_monitor_assert i_assert (.*);
